// File: hw/icache_pkg.sv
package icache_pkg;

    // Geometry
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int N_WAY      = 2;
    localparam int N_SET      = 16;
    localparam int LINE_WORDS = 4;

    // Address fields, derived from the geometry
    localparam int BOFF_W = 2;                          // Byte bits inside a word
    localparam int IDX_W  = $clog2(N_SET);              // 4
    localparam int OFF_W  = $clog2(LINE_WORDS);         // 2
    localparam int TAG_W  = ADDR_W - IDX_W - OFF_W - BOFF_W; // 24
    localparam int LINE_W = LINE_WORDS * WORD_W;        // 128

    // Physical address as seen by the cache, MSB first
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [IDX_W-1:0]  idx;
        logic [OFF_W-1:0]  off;   // Word within the line
        logic [BOFF_W-1:0] boff;  // Always zero for fetch
    } icache_addr_t;

    // Contents of the request register
    typedef struct packed {
        logic         valid;
        icache_addr_t addr;
    } icache_req_t;

    // Line address sent to the next level
    typedef struct packed {
        logic [TAG_W-1:0]        tag;
        logic [IDX_W-1:0]        idx;
        logic [OFF_W+BOFF_W-1:0] zero; // Word and byte bits of a line address
    } ifill_req_t;

    // Controller states
    //   READ   : lookup and hit responses
    //   MISS   : fill outstanding, line will be written
    //   REPLAY : respond from the freshly written line
    //   KILL   : fill outstanding, line will be dropped
    typedef enum logic [1:0] {
        READ   = 2'b00,
        MISS   = 2'b01,
        REPLAY = 2'b10,
        KILL   = 2'b11
    } ictrl_state_t;

endpackage

// File: hw/icache_req_stage.sv
`timescale 1ns/100ps

module icache_req_stage (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     ireq_valid_i,
    input  icache_pkg::icache_addr_t ireq_addr_i,
    input  logic                     accept_i,
    input  logic                     hold_i,
    input  logic                     clear_i,
    output icache_pkg::icache_req_t  req_o
);
    import icache_pkg::*;

    logic             valid_q;
    logic [TAG_W-1:0] tag_q;
    logic [IDX_W-1:0] idx_q;
    logic [OFF_W-1:0] off_q;

    // A held request stays valid until the controller clears it.
    // Without hold the request has been served and the slot empties.
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (accept_i && ireq_valid_i) begin
            valid_q <= 1'b1;
        end else if (clear_i || !hold_i) begin
            valid_q <= 1'b0;          // Served, killed or flushed
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept_i && !hold_i) begin
            tag_q <= ireq_addr_i.tag;
            idx_q <= ireq_addr_i.idx;
            off_q <= ireq_addr_i.off;
        end
    end

    assign req_o.valid     = valid_q;
    assign req_o.addr.tag  = tag_q;
    assign req_o.addr.idx  = idx_q;
    assign req_o.addr.off  = off_q;
    assign req_o.addr.boff = '0;      // Fetch is word aligned

endmodule

// File: hw/icache_tag_array.sv
`timescale 1ns/100ps

module icache_tag_array (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  icache_pkg::icache_req_t      req_i,
    input  logic                         fill_we_i,
    input  logic                         flush_i,
    output logic [icache_pkg::N_WAY-1:0] hit_way_o,
    output logic [icache_pkg::N_WAY-1:0] victim_way_o
);
    import icache_pkg::*;

    logic [N_SET-1:0] valid_q [N_WAY];
    logic [TAG_W-1:0] tag_q   [N_WAY][N_SET];
    logic [N_SET-1:0] rr_q;                   // Round-robin pointer per set
    logic [N_WAY-1:0] set_valid;
    logic             all_valid;
    logic [IDX_W-1:0] idx;

    assign idx = req_i.addr.idx;

    // Compare the stage-two tag against every way of the set
    always_comb begin
        for (int w = 0; w < N_WAY; w++) begin
            set_valid[w] = valid_q[w][idx];
            hit_way_o[w] = set_valid[w] && (tag_q[w][idx] == req_i.addr.tag);
        end
    end

    assign all_valid = &set_valid;

    // Lowest invalid way wins, round robin only when the set is full
    always_comb begin
        victim_way_o = '0;
        if (all_valid) begin
            victim_way_o[rr_q[idx]] = 1'b1;
        end else begin
            for (int w = N_WAY - 1; w >= 0; w--) begin
                if (!set_valid[w]) begin
                    victim_way_o    = '0;
                    victim_way_o[w] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int w = 0; w < N_WAY; w++) begin
                valid_q[w] <= '0;
            end
            rr_q <= '0;
        end else if (flush_i) begin
            for (int w = 0; w < N_WAY; w++) begin
                valid_q[w] <= '0;         // Whole cache invalid
            end
            rr_q <= '0;
        end else if (fill_we_i) begin
            for (int w = 0; w < N_WAY; w++) begin
                if (victim_way_o[w]) begin
                    valid_q[w][idx] <= 1'b1;
                end
            end
            if (all_valid) begin
                rr_q[idx] <= ~rr_q[idx];  // Next eviction goes to the other way
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_we_i) begin
            for (int w = 0; w < N_WAY; w++) begin
                if (victim_way_o[w]) begin
                    tag_q[w][idx] <= req_i.addr.tag;
                end
            end
        end
    end

endmodule

// File: hw/icache_data_array.sv
`timescale 1ns/100ps

module icache_data_array (
    input  logic                          clk_i,
    input  icache_pkg::icache_req_t       req_i,
    input  logic [icache_pkg::N_WAY-1:0]  hit_way_i,
    input  logic [icache_pkg::N_WAY-1:0]  victim_way_i,
    input  logic                          fill_we_i,
    input  logic [icache_pkg::LINE_W-1:0] fill_line_i,
    output logic [icache_pkg::WORD_W-1:0] rd_word_o
);
    import icache_pkg::*;

    logic [LINE_W-1:0] line_q [N_WAY][N_SET];
    logic [LINE_W-1:0] hit_line;

    // Fill returns the whole line in one beat
    always_ff @(posedge clk_i) begin
        if (fill_we_i) begin
            for (int w = 0; w < N_WAY; w++) begin
                if (victim_way_i[w]) begin
                    line_q[w][req_i.addr.idx] <= fill_line_i;
                end
            end
        end
    end

    // Hit vector is one-hot, so an OR acts as the way mux
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < N_WAY; w++) begin
            if (hit_way_i[w]) begin
                hit_line = hit_line | line_q[w][req_i.addr.idx];
            end
        end
    end

    // Response word register, lines up with the registered valid pulse
    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            rd_word_o <= hit_line[req_i.addr.off*WORD_W +: WORD_W];
        end
    end

endmodule

// File: hw/icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic                         ireq_valid_i,
    input  logic                         req_valid_i,    // Stage two holds a request
    input  logic [icache_pkg::N_WAY-1:0] hit_way_i,
    input  logic                         ireq_kill_i,
    input  logic                         flush_i,
    input  logic                         ifill_resp_valid_i,
    output logic                         iresp_ready_o,
    output logic                         iresp_valid_o,
    output logic                         accept_o,
    output logic                         hold_o,
    output logic                         clear_o,
    output logic                         fill_we_o,
    output logic                         ifill_req_valid_o,
    output logic                         miss_o
);
    import icache_pkg::*;

    ictrl_state_t state_q;
    ictrl_state_t state_d;

    logic is_hit;
    logic kill_or_flush;
    logic miss_seen;
    logic resp_d;
    logic resp_q;
    logic fill_req_q;
    logic miss_q;

    assign is_hit        = |hit_way_i;
    assign kill_or_flush = ireq_kill_i | flush_i;

    // A real miss in stage two, not abandoned this cycle
    assign miss_seen = (state_q == READ) && req_valid_i && !is_hit && !kill_or_flush;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= READ;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d   = state_q;
        resp_d    = 1'b0;
        fill_we_o = 1'b0;
        clear_o   = 1'b0;
        case (state_q)
            READ: begin
                if (kill_or_flush) begin
                    clear_o = 1'b1;                      // Drop stage two
                end else if (req_valid_i && is_hit) begin
                    resp_d = 1'b1;
                end else if (miss_seen) begin
                    state_d = MISS;
                end
            end
            MISS: begin
                if (ifill_resp_valid_i) begin
                    // Kill on the fill edge itself drops the line right away
                    fill_we_o = !kill_or_flush;
                    clear_o   = kill_or_flush;
                    state_d   = kill_or_flush ? READ : REPLAY;
                end else if (kill_or_flush) begin
                    clear_o = 1'b1;
                    state_d = KILL;
                end
            end
            REPLAY: begin
                resp_d  = !kill_or_flush;                // Line is written, tag now hits
                clear_o = 1'b1;                          // Miss completed
                state_d = READ;
            end
            KILL: begin
                if (ifill_resp_valid_i) begin
                    state_d = READ;                      // Line is thrown away
                end
            end
            default: begin
                state_d = READ;
            end
        endcase
    end

    // Response, fill request and PMU strobe are all one-cycle pulses
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            resp_q     <= 1'b0;
            fill_req_q <= 1'b0;
            miss_q     <= 1'b0;
        end else begin
            resp_q     <= resp_d;
            fill_req_q <= miss_seen;
            miss_q     <= miss_seen;
        end
    end

    assign iresp_valid_o     = resp_q;
    assign ifill_req_valid_o = fill_req_q;
    assign miss_o            = miss_q;

    // Ready only in READ, and not while a miss is being decided
    assign iresp_ready_o = (state_q == READ) && !flush_i && !miss_seen;
    assign accept_o      = ireq_valid_i && iresp_ready_o;
    assign hold_o        = miss_seen || (state_q != READ);

endmodule

// File: hw/icache_top.sv
`timescale 1ns/100ps

module icache_top (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          ireq_valid_i,
    input  icache_pkg::icache_addr_t      ireq_addr_i,
    input  logic                          ireq_kill_i,
    input  logic                          flush_i,
    input  logic                          ifill_resp_valid_i,
    input  logic [icache_pkg::LINE_W-1:0] ifill_line_i,
    output logic                          iresp_ready_o,
    output logic                          iresp_valid_o,
    output logic [icache_pkg::WORD_W-1:0] iresp_data_o,
    output logic                          ifill_req_valid_o,
    output icache_pkg::ifill_req_t        ifill_req_o,
    output logic                          miss_o
);
    import icache_pkg::*;

    icache_req_t      req;
    logic [N_WAY-1:0] hit_way;
    logic [N_WAY-1:0] victim_way;
    logic             accept;
    logic             hold;
    logic             clear;
    logic             fill_we;

    icache_req_stage icache_req_stage_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .ireq_valid_i (ireq_valid_i),
        .ireq_addr_i  (ireq_addr_i),
        .accept_i     (accept),
        .hold_i       (hold),
        .clear_i      (clear),
        .req_o        (req)
    );

    icache_tag_array icache_tag_array_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_i        (req),
        .fill_we_i    (fill_we),
        .flush_i      (flush_i),
        .hit_way_o    (hit_way),
        .victim_way_o (victim_way)
    );

    icache_data_array icache_data_array_inst (
        .clk_i        (clk_i),
        .req_i        (req),
        .hit_way_i    (hit_way),
        .victim_way_i (victim_way),
        .fill_we_i    (fill_we),
        .fill_line_i  (ifill_line_i),
        .rd_word_o    (iresp_data_o)
    );

    icache_ctrl icache_ctrl_inst (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .ireq_valid_i       (ireq_valid_i),
        .req_valid_i        (req.valid),
        .hit_way_i          (hit_way),
        .ireq_kill_i        (ireq_kill_i),
        .flush_i            (flush_i),
        .ifill_resp_valid_i (ifill_resp_valid_i),
        .iresp_ready_o      (iresp_ready_o),
        .iresp_valid_o      (iresp_valid_o),
        .accept_o           (accept),
        .hold_o             (hold),
        .clear_o            (clear),
        .fill_we_o          (fill_we),
        .ifill_req_valid_o  (ifill_req_valid_o),
        .miss_o             (miss_o)
    );

    // Line address of the request held during the miss
    assign ifill_req_o.tag  = req.addr.tag;
    assign ifill_req_o.idx  = req.addr.idx;
    assign ifill_req_o.zero = '0;

endmodule

// File: tests/tb_icache.sv
`timescale 1ns/100ps

module tb_icache;
    import icache_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int N_TESTS        = 6;
    localparam int TIMEOUT_CYCLES = 200 * N_TESTS;

    logic              clk_i              = 1'b0;
    logic              rstn_i             = 1'b0;
    logic              ireq_valid_i       = 1'b0;
    icache_addr_t      ireq_addr_i        = '0;
    logic              ireq_kill_i        = 1'b0;
    logic              flush_i            = 1'b0;
    logic              ifill_resp_valid_i = 1'b0;   // Driven by the memory model
    logic [LINE_W-1:0] ifill_line_i       = '0;
    logic              iresp_ready_o;
    logic              iresp_valid_o;
    logic [WORD_W-1:0] iresp_data_o;
    logic              ifill_req_valid_o;
    ifill_req_t        ifill_req_o;
    logic              miss_o;

    int          cycle      = 0;                    // Rising edges since time zero
    int          fill_count = 0;
    int          miss_count = 0;
    integer      seed       = 65;
    int          fill_delay;
    logic [31:0] fill_addr;
    logic [31:0] last_fill_addr = '0;
    logic [31:0] resp_data_q  [$];
    int          resp_cycle_q [$];

    icache_top icache_top_inst (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .ireq_valid_i       (ireq_valid_i),
        .ireq_addr_i        (ireq_addr_i),
        .ireq_kill_i        (ireq_kill_i),
        .flush_i            (flush_i),
        .ifill_resp_valid_i (ifill_resp_valid_i),
        .ifill_line_i       (ifill_line_i),
        .iresp_ready_o      (iresp_ready_o),
        .iresp_valid_o      (iresp_valid_o),
        .iresp_data_o       (iresp_data_o),
        .ifill_req_valid_o  (ifill_req_valid_o),
        .ifill_req_o        (ifill_req_o),
        .miss_o             (miss_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    always @(posedge clk_i) cycle <= cycle + 1;

    // Registered outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (rstn_i && iresp_valid_o) begin
            resp_data_q.push_back(iresp_data_o);
            resp_cycle_q.push_back(cycle);
        end
        if (rstn_i && miss_o) begin
            miss_count++;
        end
        if (rstn_i && ifill_req_valid_o) begin
            fill_count++;
            last_fill_addr = ifill_req_o;
        end
    end

    function automatic logic [LINE_W-1:0] model_line(input logic [31:0] line_addr);
        logic [LINE_W-1:0] line;
        for (int k = 0; k < LINE_WORDS; k++) begin
            line[k*WORD_W +: WORD_W] = line_addr ^ 32'(k) ^ 32'hA5A5_0000;
        end
        return line;
    endfunction

    // Next memory level answers one fill at a time after a random latency
    always begin
        @(negedge clk_i);
        if (rstn_i && ifill_req_valid_o) begin
            fill_addr          = ifill_req_o;
            fill_delay         = 2 + ($unsigned($random(seed)) % 8);   // 2 to 9 cycles
            repeat (fill_delay) @(negedge clk_i);
            ifill_resp_valid_i = 1'b1;
            ifill_line_i       = model_line(fill_addr);
            @(negedge clk_i);
            ifill_resp_valid_i = 1'b0;
        end
    end

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] line_addr;
        line_addr = {addr[31:4], 4'b0000};
        return line_addr ^ {30'b0, addr[2 +: OFF_W]} ^ 32'hA5A5_0000;
    endfunction

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    // Starts at a falling edge and returns at the falling edge after acceptance
    task automatic issue_read(input logic [31:0] addr, output int acc_edge);
        bit accepted;
        accepted     = 1'b0;
        ireq_valid_i = 1'b1;
        ireq_addr_i  = addr;
        while (!accepted) begin
            #(CLK_PERIOD/4);                         // Ready settled after the new inputs
            if (iresp_ready_o) begin
                accepted = 1'b1;
                acc_edge = cycle + 1;
            end
            @(negedge clk_i);
        end
        ireq_valid_i = 1'b0;
    endtask

    task automatic wait_responses(input int n);
        @(posedge clk_i);
        while (resp_data_q.size() < n) begin
            @(posedge clk_i);
        end
        @(negedge clk_i);
    endtask

    task automatic read_and_check(input logic [31:0] addr, input bit expect_miss);
        int fills_before;
        int misses_before;
        int acc_edge;
        fills_before  = fill_count;
        misses_before = miss_count;
        resp_data_q.delete();
        resp_cycle_q.delete();
        issue_read(addr, acc_edge);
        wait_responses(1);
        idle_cycles(2);
        check_value("response count", 32'(resp_data_q.size()), 32'd1);
        check_value("iresp_data_o", resp_data_q[0], expected_word(addr));
        check_value("fill requests", 32'(fill_count - fills_before), 32'(expect_miss));
        check_value("miss_o pulses", 32'(miss_count - misses_before), 32'(expect_miss));
        if (expect_miss) begin
            check_value("ifill_req_o", last_fill_addr, {addr[31:4], 4'b0000});
        end else begin
            check_value("hit latency", 32'(resp_cycle_q[0]), 32'(acc_edge + 1));
        end
    endtask

    task automatic reset_outputs();
        check_value("iresp_ready_o", 32'(iresp_ready_o), 32'd1);
        check_value("iresp_valid_o", 32'(iresp_valid_o), 32'd0);
        check_value("ifill_req_valid_o", 32'(ifill_req_valid_o), 32'd0);
        check_value("miss_o", 32'(miss_o), 32'd0);
    endtask

    task automatic cold_miss_fill();
        read_and_check(32'h0000_1044, 1'b1);         // Word 1 of set 4
    endtask

    task automatic hit_streaming();
        int acc_edge [LINE_WORDS];
        int fills_before;
        fills_before = fill_count;
        resp_data_q.delete();
        resp_cycle_q.delete();
        for (int k = 0; k < LINE_WORDS; k++) begin
            issue_read(32'h0000_1040 + 32'(4 * k), acc_edge[k]);
        end
        wait_responses(LINE_WORDS);
        idle_cycles(2);
        check_value("response count", 32'(resp_data_q.size()), 32'(LINE_WORDS));
        for (int k = 0; k < LINE_WORDS; k++) begin
            check_value("iresp_data_o", resp_data_q[k], expected_word(32'h0000_1040 + 32'(4 * k)));
            check_value("hit latency", 32'(resp_cycle_q[k]), 32'(acc_edge[k] + 1));
            check_value("accept spacing", 32'(acc_edge[k] - acc_edge[0]), 32'(k));
        end
        check_value("fill requests", 32'(fill_count - fills_before), 32'd0);
    endtask

    task automatic way_replacement();
        read_and_check(32'h0000_2090, 1'b1);         // A lands in way 0
        read_and_check(32'h0000_3094, 1'b1);         // B lands in way 1
        read_and_check(32'h0000_4098, 1'b1);         // C evicts A
        read_and_check(32'h0000_309C, 1'b0);         // B still resident
        read_and_check(32'h0000_2094, 1'b1);         // A evicts B
        read_and_check(32'h0000_4090, 1'b0);
    endtask

    task automatic kill_pending_miss();
        int fills_before;
        int acc_edge;
        fills_before = fill_count;
        resp_data_q.delete();
        resp_cycle_q.delete();
        issue_read(32'h0000_50A8, acc_edge);
        while (!ifill_req_valid_o) begin
            @(negedge clk_i);
        end
        ireq_kill_i = 1'b1;                          // Controller is in MISS here
        @(negedge clk_i);
        ireq_kill_i = 1'b0;
        @(posedge clk_i);
        while (!ifill_resp_valid_i) begin
            @(posedge clk_i);
        end
        idle_cycles(4);
        check_value("response count", 32'(resp_data_q.size()), 32'd0);
        check_value("fill requests", 32'(fill_count - fills_before), 32'd1);
        check_value("iresp_ready_o", 32'(iresp_ready_o), 32'd1);
        read_and_check(32'h0000_50A8, 1'b1);         // Line was dropped
    endtask

    task automatic flush_invalidate();
        read_and_check(32'h0000_104C, 1'b0);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        idle_cycles(1);
        read_and_check(32'h0000_104C, 1'b1);
        read_and_check(32'h0000_4090, 1'b1);         // Other sets are gone too
    endtask

    initial begin
        repeat (2) @(negedge clk_i);
        rstn_i = 1'b1;
        @(negedge clk_i);
        reset_outputs();
        cold_miss_fill();
        hit_streaming();
        way_replacement();
        kill_pending_miss();
        flush_invalidate();
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_with_failure();
    end

endmodule

// File: filelist.f
hw/icache_pkg.sv
hw/icache_req_stage.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tests/tb_icache.sv

// File: run_sim.sh
#!/bin/sh
# Build the instruction cache testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_icache -f filelist.f -o sim_icache &&
./obj_dir/sim_icache &&
echo "Simulation run completed" ||
{ echo "Build or simulation failed"; exit 1; }
